// ==== jpeg_defs.svh ====
`ifndef JPEG_DEFS_SVH
`define JPEG_DEFS_SVH

// width of one quantized DCT coefficient.
`define COEF_W 16

// coefficients in one row of an 8x8 block.
`define ROW_LEN 8

// words in the reorder RAM.
// each word holds two coefficients, so one block fills 32 words
// and the ping-pong pair of blocks fills 64.
`define RAM_DEPTH 64

// upper bound, in clock cycles, for any wait in the testbench.
`define TB_TIMEOUT 2000

`endif

// ==== jpeg_pkg.sv ====
`include "jpeg_defs.svh"

package jpeg_pkg;

    typedef logic signed [`COEF_W-1:0] coef_t;
    typedef logic [2:0] row_idx_t;
    typedef logic [4:0] pair_idx_t;
    typedef logic [5:0] zz_addr_t;
    typedef logic [3:0] run_t;

    typedef enum logic [1:0] {
        RLC_IDLE,
        RLC_SECOND,
        RLC_ZRL,
        RLC_EOB
    } rlc_state_t;

    // coarser quantization toward the high-frequency corner.
    function automatic logic [2:0] quant_shift(row_idx_t row, logic [2:0] col);
        logic [2:0] m;
        m = (row > col) ? row : col;
        return 3'd1 + (m >> 1);
    endfunction

    // standard JPEG zigzag scan position of (row, col).
    function automatic zz_addr_t zigzag_pos(row_idx_t row, logic [2:0] col);
        int r;
        int c;
        int s;
        int base;
        int offs;
        r = int'(row);
        c = int'(col);
        s = r + c;
        if (s < 8) begin
            base = s * (s + 1) / 2;
            offs = (s % 2 == 1) ? r : c;
        end else begin
            // the lower-right triangle is counted back from position 63.
            base = 64 - (15 - s) * (16 - s) / 2;
            offs = (s % 2 == 1) ? r - (s - 7) : c - (s - 7);
        end
        return zz_addr_t'(base + offs);
    endfunction

endpackage

// ==== zigzag_ram.sv ====
`include "jpeg_defs.svh"

module zigzag_ram (
    input  logic                          clk,
    input  logic [$clog2(`RAM_DEPTH)-1:0] wa_i,
    input  logic [2*`COEF_W-1:0]          wd_i,
    input  logic [1:0]                    wbe_i,
    input  logic                          we_i,
    input  logic [$clog2(`RAM_DEPTH)-1:0] ra_i,
    input  logic                          re_i,
    output logic [2*`COEF_W-1:0]          rd_o
);

    logic [2*`COEF_W-1:0] mem [`RAM_DEPTH];

    // each half-word has its own enable.
    always_ff @(posedge clk) begin
        if (we_i) begin
            if (wbe_i[0]) begin
                mem[wa_i][`COEF_W-1:0] <= wd_i[`COEF_W-1:0];
            end
            if (wbe_i[1]) begin
                mem[wa_i][2*`COEF_W-1:`COEF_W] <= wd_i[2*`COEF_W-1:`COEF_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (re_i) begin
            rd_o <= mem[ra_i];
        end
    end

endmodule

// ==== coef_quantizer.sv ====
`include "jpeg_defs.svh"

module coef_quantizer (
    input  logic                clk,
    input  logic                resetn,

    input  jpeg_pkg::coef_t     coef_i [`ROW_LEN],
    input  jpeg_pkg::row_idx_t  row_i,
    input  logic                row_valid_i,
    output logic                row_hold_o,

    output jpeg_pkg::coef_t     q_row_o [`ROW_LEN],
    output jpeg_pkg::row_idx_t  q_row_idx_o,
    output logic                q_row_valid_o,
    input  logic                q_hold_i
);
    import jpeg_pkg::*;

    coef_t                         quant [`ROW_LEN];
    logic                          accept;
    logic [`ROW_LEN*`COEF_W-1:0]   q_row_flat;

    // arithmetic shift that rounds toward zero for negative inputs.
    function automatic coef_t quantize(coef_t x, logic [2:0] s);
        coef_t bias;
        bias = (x < 0) ? coef_t'((1 << s) - 1) : '0;
        return (x + bias) >>> s;
    endfunction

    always_comb begin
        for (int c = 0; c < `ROW_LEN; c++) begin
            quant[c] = quantize(coef_i[c], quant_shift(row_i, 3'(c)));
        end
    end

    // the row register is busy while the buffer is still taking its columns.
    assign row_hold_o = q_row_valid_o & q_hold_i;
    assign accept     = row_valid_i & ~row_hold_o;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            q_row_valid_o <= 1'b0;
        end else if (accept) begin
            q_row_valid_o <= 1'b1;
        end else if (!q_hold_i) begin
            q_row_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            q_row_o     <= quant;
            q_row_idx_o <= row_i;
        end
    end

    always_comb begin
        for (int c = 0; c < `ROW_LEN; c++) begin
            q_row_flat[c*`COEF_W +: `COEF_W] = q_row_o[c];
        end
    end

    // the buffer reads one column per cycle from a row it has not released.
    a_row_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        q_row_valid_o && q_hold_i |=>
            q_row_valid_o && $stable(q_row_flat) && $stable(q_row_idx_o)
    );

endmodule

// ==== zigzag_buffer.sv ====
`include "jpeg_defs.svh"

module zigzag_buffer (
    input  logic                 clk,
    input  logic                 resetn,

    input  jpeg_pkg::coef_t      d_i [`ROW_LEN],
    input  jpeg_pkg::row_idx_t   d_row_i,
    input  logic                 d_valid_i,
    output logic                 d_hold_o,

    output jpeg_pkg::coef_t      q_o [2],
    output jpeg_pkg::pair_idx_t  q_cnt_o,
    output logic                 q_valid_o,
    input  logic                 q_hold_i
);
    import jpeg_pkg::*;

    localparam int AW = $clog2(`RAM_DEPTH);

    logic [1:0]            wptr;
    logic [1:0]            rptr;
    logic [2:0]            wr_col;
    pair_idx_t             rd_cnt;
    logic                  full;
    logic                  empty;

    zz_addr_t              wr_pos;
    coef_t                 wr_coef;
    logic [AW-1:0]         wa;
    logic [2*`COEF_W-1:0]  wd;
    logic [1:0]            wbe;
    logic                  we;

    logic [AW-1:0]         ra;
    logic [2*`COEF_W-1:0]  rd;
    logic                  re;
    logic                  rd_go;
    logic                  rd_fresh;
    logic [2*`COEF_W-1:0]  hold_pair;

    // the extra pointer bit tells a full RAM from an empty one.
    assign full  = (wptr[1] != rptr[1]) && (wptr[0] == rptr[0]);
    assign empty = (wptr == rptr);

    // a row is released only on its last column.
    assign d_hold_o = full | (wr_col != 3'(`ROW_LEN - 1));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wptr   <= '0;
            wr_col <= '0;
        end else if (we) begin
            wr_col <= wr_col + 3'd1;
            if (&wr_col && &d_row_i) begin
                wptr <= wptr + 2'd1;
            end
        end
    end

    assign we      = d_valid_i & ~full;
    assign wr_coef = d_i[wr_col];
    assign wr_pos  = zigzag_pos(d_row_i, wr_col);

    // even zigzag positions go to the low half of a word.
    assign wa  = {wptr[0], wr_pos[5:1]};
    assign wd  = {wr_coef, wr_coef};
    assign wbe = wr_pos[0] ? 2'b10 : 2'b01;

    assign rd_go = ~empty & ~q_hold_i;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rptr   <= '0;
            rd_cnt <= '0;
        end else if (rd_go) begin
            rd_cnt <= rd_cnt + 5'd1;
            if (&rd_cnt) begin
                rptr <= rptr + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            q_cnt_o <= rd_cnt;
        end
    end

    // the RAM keeps reading ahead, so the pair is kept in hold_pair after its first cycle.
    assign ra = {rptr[0], rd_cnt};
    assign re = ~empty;

    zigzag_ram ram_i (
        .clk   (clk),
        .wa_i  (wa),
        .wd_i  (wd),
        .wbe_i (wbe),
        .we_i  (we),
        .ra_i  (ra),
        .re_i  (re),
        .rd_o  (rd)
    );

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_fresh <= 1'b0;
        end else begin
            rd_fresh <= rd_go;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fresh) begin
            hold_pair <= rd;
        end
    end

    always_comb begin
        q_o[0] = rd_fresh ? coef_t'(rd[`COEF_W-1:0]) : coef_t'(hold_pair[`COEF_W-1:0]);
        q_o[1] = rd_fresh ? coef_t'(rd[2*`COEF_W-1:`COEF_W])
                          : coef_t'(hold_pair[2*`COEF_W-1:`COEF_W]);
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            q_valid_o <= 1'b0;
        end else if (!q_hold_i) begin
            q_valid_o <= ~empty;
        end
    end

    // the writer is never more than both blocks ahead of the reader, and the reader never
    // passes the writer.
    a_no_write_full: assert property (
        @(posedge clk) disable iff (!resetn)
        (wptr - rptr) != 2'd3
    );

    // back-to-back pairs follow each other in zigzag order, wrapping per block.
    a_read_order: assert property (
        @(posedge clk) disable iff (!resetn)
        q_valid_o && !q_hold_i ##1 q_valid_o |-> q_cnt_o == $past(q_cnt_o) + 5'd1
    );

endmodule

// ==== run_length_coder.sv ====
`include "jpeg_defs.svh"

module run_length_coder (
    input  logic                 clk,
    input  logic                 resetn,

    input  jpeg_pkg::coef_t      pair_i [2],
    input  jpeg_pkg::pair_idx_t  pair_idx_i,
    input  logic                 pair_valid_i,
    output logic                 pair_hold_o,

    output jpeg_pkg::run_t       sym_run_o,
    output jpeg_pkg::coef_t      sym_value_o,
    output logic                 sym_eob_o,
    output logic                 sym_valid_o,
    input  logic                 sym_hold_i
);
    import jpeg_pkg::*;

    rlc_state_t  state;
    rlc_state_t  state_nxt;
    logic [5:0]  zeros;
    logic [5:0]  zeros_nxt;
    coef_t       val1_q;
    logic        last_q;
    coef_t       pend_val;
    logic        pend_second;

    coef_t       cur_v;
    logic [5:0]  cur_z;
    logic        cur_second;
    logic        cur_last;
    logic        cur_dc;

    logic        emit;
    run_t        e_run;
    coef_t       e_val;
    logic        e_eob;
    logic        advance;
    logic        step;

    assign advance     = ~(sym_valid_o & sym_hold_i);
    assign step        = (state != RLC_IDLE) | pair_valid_i;
    assign pair_hold_o = (state != RLC_IDLE) | ~advance;

    // pick the coefficient to place this cycle.
    // a zero first AC value is folded into the run so the second is placed at once.
    always_comb begin
        cur_v      = pair_i[0];
        cur_z      = zeros;
        cur_second = 1'b0;
        cur_last   = &pair_idx_i;
        cur_dc     = 1'b0;
        case (state)
            RLC_IDLE: begin
                cur_dc = (pair_idx_i == '0);
                if (!cur_dc && pair_i[0] == '0) begin
                    cur_v      = pair_i[1];
                    cur_z      = zeros + 6'd1;
                    cur_second = 1'b1;
                end
            end
            RLC_SECOND: begin
                cur_v      = val1_q;
                cur_second = 1'b1;
                cur_last   = last_q;
            end
            default: begin
                cur_v      = pend_val;
                cur_second = pend_second;
                cur_last   = last_q;
            end
        endcase
    end

    always_comb begin
        emit      = 1'b0;
        e_run     = '0;
        e_val     = '0;
        e_eob     = 1'b0;
        zeros_nxt = cur_z;
        state_nxt = state;
        if (state == RLC_EOB) begin
            emit      = 1'b1;
            e_eob     = 1'b1;
            zeros_nxt = '0;
            state_nxt = RLC_IDLE;
        end else if (cur_dc) begin
            emit      = 1'b1;
            e_val     = cur_v;
            zeros_nxt = '0;
            state_nxt = RLC_SECOND;
        end else if (cur_v == '0) begin
            zeros_nxt = cur_z + 6'd1;
            state_nxt = cur_last ? RLC_EOB : RLC_IDLE;
        end else if (cur_z >= 6'd16) begin
            // ZRL, then the same value is tried again with 16 fewer zeros.
            emit      = 1'b1;
            e_run     = 4'd15;
            zeros_nxt = cur_z - 6'd16;
            state_nxt = RLC_ZRL;
        end else begin
            emit      = 1'b1;
            e_run     = cur_z[3:0];
            e_val     = cur_v;
            zeros_nxt = '0;
            state_nxt = cur_second ? RLC_IDLE : RLC_SECOND;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= RLC_IDLE;
            zeros       <= '0;
            sym_valid_o <= 1'b0;
        end else if (advance) begin
            if (!step) begin
                sym_valid_o <= 1'b0;
            end else begin
                sym_valid_o <= emit;
                state       <= state_nxt;
                zeros       <= zeros_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && step) begin
            sym_run_o   <= e_run;
            sym_value_o <= e_val;
            sym_eob_o   <= e_eob;
            if (state_nxt == RLC_ZRL) begin
                pend_val    <= cur_v;
                pend_second <= cur_second;
            end
        end
        if (state == RLC_IDLE && advance && pair_valid_i) begin
            val1_q <= pair_i[1];
            last_q <= &pair_idx_i;
        end
    end

    a_sym_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        sym_valid_o && sym_hold_i |=>
            sym_valid_o && $stable(sym_run_o) && $stable(sym_value_o) && $stable(sym_eob_o)
    );

endmodule

// ==== jpeg_block_coder.sv ====
`include "jpeg_defs.svh"

module jpeg_block_coder (
    input  logic                clk,
    input  logic                resetn,

    input  jpeg_pkg::coef_t     coef_i [`ROW_LEN],
    input  jpeg_pkg::row_idx_t  row_i,
    input  logic                row_valid_i,
    output logic                row_hold_o,

    output jpeg_pkg::run_t      sym_run_o,
    output jpeg_pkg::coef_t     sym_value_o,
    output logic                sym_eob_o,
    output logic                sym_valid_o,
    input  logic                sym_hold_i
);
    import jpeg_pkg::*;

    coef_t      q_row [`ROW_LEN];
    row_idx_t   q_row_idx;
    logic       q_row_valid;
    logic       buf_hold;

    coef_t      zz_pair [2];
    pair_idx_t  zz_pair_idx;
    logic       zz_valid;
    logic       coder_hold;

    coef_quantizer quant_i (
        .clk           (clk),
        .resetn        (resetn),
        .coef_i        (coef_i),
        .row_i         (row_i),
        .row_valid_i   (row_valid_i),
        .row_hold_o    (row_hold_o),
        .q_row_o       (q_row),
        .q_row_idx_o   (q_row_idx),
        .q_row_valid_o (q_row_valid),
        .q_hold_i      (buf_hold)
    );

    zigzag_buffer zz_buf_i (
        .clk       (clk),
        .resetn    (resetn),
        .d_i       (q_row),
        .d_row_i   (q_row_idx),
        .d_valid_i (q_row_valid),
        .d_hold_o  (buf_hold),
        .q_o       (zz_pair),
        .q_cnt_o   (zz_pair_idx),
        .q_valid_o (zz_valid),
        .q_hold_i  (coder_hold)
    );

    run_length_coder rlc_i (
        .clk          (clk),
        .resetn       (resetn),
        .pair_i       (zz_pair),
        .pair_idx_i   (zz_pair_idx),
        .pair_valid_i (zz_valid),
        .pair_hold_o  (coder_hold),
        .sym_run_o    (sym_run_o),
        .sym_value_o  (sym_value_o),
        .sym_eob_o    (sym_eob_o),
        .sym_valid_o  (sym_valid_o),
        .sym_hold_i   (sym_hold_i)
    );

endmodule

// ==== tb_jpeg_block_coder.sv ====
`include "jpeg_defs.svh"

module tb_jpeg_block_coder;
    import jpeg_pkg::*;

    localparam int MEM_WORDS = 512;

    logic       clk;
    logic       resetn;
    coef_t      coef_i [`ROW_LEN];
    row_idx_t   row_i;
    logic       row_valid_i;
    logic       row_hold_o;
    run_t       sym_run_o;
    coef_t      sym_value_o;
    logic       sym_eob_o;
    logic       sym_valid_o;
    logic       sym_hold_i;

    logic [`COEF_W-1:0]           data_mem [MEM_WORDS];
    row_idx_t                     row_idx_q [$];
    logic [`ROW_LEN*`COEF_W-1:0]  row_data_q [$];
    run_t                         exp_run_q [$];
    coef_t                        exp_value_q [$];
    logic                         exp_eob_q [$];
    logic                         random_mode;

    jpeg_block_coder dut_i (
        .clk         (clk),
        .resetn      (resetn),
        .coef_i      (coef_i),
        .row_i       (row_i),
        .row_valid_i (row_valid_i),
        .row_hold_o  (row_hold_o),
        .sym_run_o   (sym_run_o),
        .sym_value_o (sym_value_o),
        .sym_eob_o   (sym_eob_o),
        .sym_valid_o (sym_valid_o),
        .sym_hold_i  (sym_hold_i)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_run(input run_t actual, input run_t expected, input int idx);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[ERROR] sym_run_o (symbol %0d): got 0x%h, expected 0x%h",
                                        idx, actual, expected));
        end
    endtask

    task automatic check_value(input coef_t actual, input coef_t expected, input int idx);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[ERROR] sym_value_o (symbol %0d): got 0x%h, expected 0x%h",
                                        idx, actual, expected));
        end
    endtask

    task automatic check_eob(input logic actual, input logic expected, input int idx);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[ERROR] sym_eob_o (symbol %0d): got 0x%h, expected 0x%h",
                                        idx, actual, expected));
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h",
                                        name, actual, expected));
        end
    endtask

    // tag 1 is followed by a row index and eight columns, tag 2 by run, value and eob.
    task automatic read_stimulus_file();
        int                           p;
        logic                         done;
        logic [`ROW_LEN*`COEF_W-1:0]  bits;
        p = 0;
        done = 1'b0;
        $readmemh("block_input.txt", data_mem);
        while (p < MEM_WORDS - (`ROW_LEN + 2) && !done) begin
            if (data_mem[p] == 1) begin
                row_idx_q.push_back(row_idx_t'(data_mem[p+1]));
                for (int c = 0; c < `ROW_LEN; c++) begin
                    bits[c*`COEF_W +: `COEF_W] = data_mem[p+2+c];
                end
                row_data_q.push_back(bits);
                p = p + 2 + `ROW_LEN;
            end else if (data_mem[p] == 2) begin
                exp_run_q.push_back(run_t'(data_mem[p+1]));
                exp_value_q.push_back(coef_t'(data_mem[p+2]));
                exp_eob_q.push_back(data_mem[p+3][0]);
                p = p + 4;
            end else begin
                done = 1'b1;
            end
        end
        if (row_data_q.size() == 0 || exp_run_q.size() == 0) begin
            stop_with_failure("could not read any rows or symbols from block_input.txt");
        end
    endtask

    task automatic send_row(input int n);
        int                           waited;
        int                           gap;
        logic [`ROW_LEN*`COEF_W-1:0]  bits;
        waited = 0;
        gap = random_mode ? int'($urandom % 4) : 0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        bits = row_data_q[n];
        row_i = row_idx_q[n];
        for (int c = 0; c < `ROW_LEN; c++) begin
            coef_i[c] = bits[c*`COEF_W +: `COEF_W];
        end
        row_valid_i = 1'b1;
        @(negedge clk);
        while (row_hold_o) begin
            waited++;
            if (waited > `TB_TIMEOUT) begin
                stop_with_failure($sformatf("timed out waiting to hand over row entry %0d", n));
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        row_valid_i = 1'b0;
    endtask

    task automatic receive_symbol(input int k);
        int    waited;
        logic  got;
        waited = 0;
        got = 1'b0;
        while (!got) begin
            @(posedge clk);
            #1;
            sym_hold_i = random_mode ? ($urandom % 3 == 0) : 1'b0;
            @(negedge clk);
            if (sym_valid_o && !sym_hold_i) begin
                got = 1'b1;
            end else begin
                waited++;
                if (waited > `TB_TIMEOUT) begin
                    stop_with_failure($sformatf("timed out waiting for expected symbol %0d", k));
                end
            end
        end
        check_run(sym_run_o, exp_run_q[k], k);
        check_value(sym_value_o, exp_value_q[k], k);
        check_eob(sym_eob_o, exp_eob_q[k], k);
    endtask

    // rows go in while symbols come out, so later blocks are written during earlier reads.
    task feed_and_drain(input logic use_random);
        random_mode = use_random;
        @(posedge clk);
        #1;
        fork
            begin
                for (int n = 0; n < row_idx_q.size(); n++) begin
                    send_row(n);
                end
            end
            begin
                for (int k = 0; k < exp_run_q.size(); k++) begin
                    receive_symbol(k);
                end
            end
        join
    endtask

    task automatic confirm_no_extra_symbols();
        @(posedge clk);
        #1;
        sym_hold_i = 1'b0;
        repeat (50) begin
            @(negedge clk);
            if (sym_valid_o) begin
                stop_with_failure("a symbol came out after the last expected one");
            end
        end
    endtask

    initial begin
        void'($urandom(67471));
        resetn = 1'b0;
        row_valid_i = 1'b0;
        row_i = '0;
        sym_hold_i = 1'b0;
        random_mode = 1'b0;
        for (int c = 0; c < `ROW_LEN; c++) begin
            coef_i[c] = '0;
        end
        read_stimulus_file();
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;
        @(negedge clk);
        check_flag("row_hold_o", row_hold_o, 1'b0);
        check_flag("sym_valid_o", sym_valid_o, 1'b0);
        // the first pass streams blocks back to back, the second adds gaps and stalls.
        feed_and_drain(1'b0);
        feed_and_drain(1'b1);
        confirm_no_extra_symbols();
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== block_input.txt ====
// tag 1: raw row, then row index and columns 0 to 7 as 16-bit two's complement
// tag 2: expected symbol, then run, value and eob flag
// block 0: low-frequency values with negatives, two ZRL before (4,4), ends with EOB.
1 0 03E8 FF9C 0025 FFFD 0000 0000 0000 0000
1 1 FFDB 0032 0000 0000 0000 0000 0000 0000
1 2 FFF9 0000 0000 0000 0000 0000 0000 0000
1 3 0000 0000 0000 0000 0000 0000 0000 0000
1 4 0000 0000 0000 0000 FF9C 0000 0000 0000
1 5 0000 0000 0000 0000 0000 0000 0000 0000
1 6 0000 0000 0000 0000 0000 0000 0000 0000
1 7 0000 0000 0000 0000 0000 0000 0000 0000
2 0 01F4 0
2 0 FFCE 0
2 0 FFEE 0
2 0 FFFF 0
2 0 0019 0
2 0 0009 0
2 F 0000 0
2 F 0000 0
2 1 FFF4 0
2 0 0000 1
// block 1: a single value at row 2, column 1, which is zigzag position 8.
1 0 0000 0000 0000 0000 0000 0000 0000 0000
1 1 0000 0000 0000 0000 0000 0000 0000 0000
1 2 0000 FF35 0000 0000 0000 0000 0000 0000
1 3 0000 0000 0000 0000 0000 0000 0000 0000
1 4 0000 0000 0000 0000 0000 0000 0000 0000
1 5 0000 0000 0000 0000 0000 0000 0000 0000
1 6 0000 0000 0000 0000 0000 0000 0000 0000
1 7 0000 0000 0000 0000 0000 0000 0000 0000
2 0 0000 0
2 7 FFCE 0
2 0 0000 1
// block 2: the last coefficient is nonzero, so no EOB.
1 0 FFC0 0000 0000 0000 0000 0000 0000 0000
1 1 0000 0000 0000 0000 0000 0000 0000 0000
1 2 0000 0000 0000 0000 0000 0000 0000 0000
1 3 0000 0000 0000 002D 0000 0000 0000 0000
1 4 0000 0000 0000 0000 0000 0000 0000 0000
1 5 0000 0000 0000 0000 0000 0000 0000 0000
1 6 0000 0000 0000 0000 0000 0000 0000 0000
1 7 0000 0000 0000 0000 0000 0000 0000 FFDF
2 0 FFE0 0
2 F 0000 0
2 7 000B 0
2 F 0000 0
2 F 0000 0
2 6 FFFE 0
0

// ==== sim.f ====
+incdir+.
jpeg_pkg.sv
zigzag_ram.sv
coef_quantizer.sv
zigzag_buffer.sv
run_length_coder.sv
jpeg_block_coder.sv
tb_jpeg_block_coder.sv

// ==== Bender.yml ====
package:
  name: jpeg_block_coder

sources:
  - include_dirs:
      - .
    files:
      - jpeg_pkg.sv
      - zigzag_ram.sv
      - coef_quantizer.sv
      - zigzag_buffer.sv
      - run_length_coder.sv
      - jpeg_block_coder.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_jpeg_block_coder.sv
